// File: common/mem_access_params.svh
`ifndef MEM_ACCESS_PARAMS_SVH
`define MEM_ACCESS_PARAMS_SVH

// Data path width, one RAM word
`define MA_WORD_W 32

// Byte offset bits inside a word
`define MA_OFF_W 2

// RAM depth in words
// Kept a power of two so the word index wraps cleanly
`define MA_MEM_WORDS 1024

// Write mask with every bit enabled
`define MA_FULL_MASK {`MA_WORD_W{1'b1}}

`endif

// File: common/mem_access_pkg.sv
`include "mem_access_params.svh"

package mem_access_pkg;

    // Data word as seen on both sides of the controller
    typedef logic [`MA_WORD_W-1:0] word_t;

    // Byte address, any alignment on the request side
    typedef logic [`MA_WORD_W-1:0] addr_t;

    // Per-bit write enable, 1 takes the new bit
    typedef logic [`MA_WORD_W-1:0] mask_t;

    // Position of the first byte inside its word
    typedef logic [`MA_OFF_W-1:0] byte_off_t;

    // Sequencer states
    typedef enum logic [3:0] {
        idle,
        issue_first,
        finish,
        // Write paths
        read_before_write,
        issue_write,
        issue_next_before_write,
        read_next_before_write,
        issue_write_low,
        issue_write_high,
        // Read paths
        wait_read,
        issue_next_read,
        wait_next_read
    } seq_state_t;

endpackage

// File: common/mem_word_if.sv
`timescale 1ns/1ns

interface mem_word_if;

    // Command side, driven by the sequencer
    logic                  cmd_start;
    logic                  cmd_write;
    mem_access_pkg::addr_t addr;
    mem_access_pkg::word_t wdata;

    // Response side, driven by the RAM
    logic                  cmd_ready;
    mem_access_pkg::word_t rdata;
    logic                  rdata_valid;

    modport ctrl (
        output cmd_start, cmd_write, addr, wdata,
        input  cmd_ready, rdata, rdata_valid
    );

    modport ram (
        input  cmd_start, cmd_write, addr, wdata,
        output cmd_ready, rdata, rdata_valid
    );

endinterface

// File: rtl/access_ctrl/lane_merge.sv
`timescale 1ns/1ns
`include "mem_access_params.svh"

module lane_merge (
    input  mem_access_pkg::byte_off_t offset,
    input  mem_access_pkg::word_t     save_wdata,
    input  mem_access_pkg::mask_t     save_wmask,
    input  mem_access_pkg::word_t     low_word,
    input  mem_access_pkg::word_t     high_word,
    input  mem_access_pkg::word_t     mem_rdata,
    output mem_access_pkg::word_t     merged_low,
    output mem_access_pkg::word_t     merged_high,
    output mem_access_pkg::word_t     read_word
);

    // Two adjacent words treated as one little-endian window
    localparam int PAIR_W = 2 * `MA_WORD_W;

    // Byte offset scaled to a bit shift, 0 to 24
    logic [`MA_OFF_W+2:0] shift_bits;

    // Write side, new data and mask placed at their byte lanes
    logic [PAIR_W-1:0] data_pair;
    logic [PAIR_W-1:0] mask_pair;

    // Old contents of the low and high words
    logic [PAIR_W-1:0] old_pair;
    logic [PAIR_W-1:0] new_pair;

    // Read side window, RAM word on top of the saved low word
    logic [PAIR_W-1:0] read_pair;

    assign shift_bits = {offset, 3'b000};

    // Byte i of the request lands in lane offset+i of the pair
    // Lanes past 3 spill into the high word
    assign data_pair = {{`MA_WORD_W{1'b0}}, save_wdata} << shift_bits;
    assign mask_pair = {{`MA_WORD_W{1'b0}}, save_wmask} << shift_bits;

    assign old_pair = {high_word, low_word};

    // Mask bit set takes the new bit, clear keeps the old one
    assign new_pair = (old_pair & ~mask_pair) | (data_pair & mask_pair);

    // Offset 0 leaves the high half unmasked, so the low half is the
    // plain aligned read-modify-write word
    assign merged_low  = new_pair[`MA_WORD_W-1:0];
    assign merged_high = new_pair[PAIR_W-1:`MA_WORD_W];

    // Upper lanes of the low word, then lower lanes of the next word
    assign read_pair = {mem_rdata, low_word} >> shift_bits;
    assign read_word = read_pair[`MA_WORD_W-1:0];

endmodule

// File: rtl/access_ctrl/access_seq.sv
`timescale 1ns/1ns
`include "mem_access_params.svh"

module access_seq (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cmd_start,
    input  logic                      cmd_write,
    output logic                      cmd_ready,
    input  mem_access_pkg::addr_t     addr,
    input  mem_access_pkg::word_t     wdata,
    input  mem_access_pkg::mask_t     wmask,
    output mem_access_pkg::word_t     rdata,
    output logic                      rdata_valid,
    mem_word_if.ctrl                  mem,
    output mem_access_pkg::byte_off_t offset,
    output mem_access_pkg::word_t     save_wdata,
    output mem_access_pkg::mask_t     save_wmask,
    output mem_access_pkg::word_t     low_word,
    output mem_access_pkg::word_t     high_word,
    input  mem_access_pkg::word_t     merged_low,
    input  mem_access_pkg::word_t     merged_high,
    input  mem_access_pkg::word_t     read_word
);

    mem_access_pkg::seq_state_t state;

    // Captured request
    logic                  save_write;
    mem_access_pkg::addr_t save_addr;

    logic                  aligned;
    logic                  full_write;
    mem_access_pkg::addr_t base_addr;
    mem_access_pkg::addr_t next_addr;

    assign offset     = save_addr[`MA_OFF_W-1:0];
    assign aligned    = (offset == '0);
    // Whole aligned word replaced, no old data needed
    assign full_write = save_write && aligned && (save_wmask == `MA_FULL_MASK);

    assign base_addr = {save_addr[`MA_WORD_W-1:`MA_OFF_W], {`MA_OFF_W{1'b0}}};
    // Wraps past the top, RAM folds it back to word 0
    assign next_addr = base_addr + mem_access_pkg::addr_t'(4);

    // Requests only taken while nothing is in flight
    assign cmd_ready = (state == mem_access_pkg::idle);

    // Second word read finishes an unaligned read through the merger
    assign rdata = (state == mem_access_pkg::wait_next_read) ? read_word : mem.rdata;
    assign rdata_valid = mem.rdata_valid &&
                         (((state == mem_access_pkg::wait_read) && aligned) ||
                          (state == mem_access_pkg::wait_next_read));

    // Word-side command, held until the RAM is ready
    always_comb begin
        mem.cmd_start = 1'b0;
        mem.cmd_write = 1'b0;
        mem.addr      = base_addr;
        mem.wdata     = save_wdata;
        case (state)
            mem_access_pkg::issue_first: begin
                // Read of the low word, or the direct write
                mem.cmd_start = 1'b1;
                mem.cmd_write = full_write;
            end
            mem_access_pkg::issue_write,
            mem_access_pkg::issue_write_low: begin
                mem.cmd_start = 1'b1;
                mem.cmd_write = 1'b1;
                mem.wdata     = merged_low;
            end
            mem_access_pkg::issue_write_high: begin
                mem.cmd_start = 1'b1;
                mem.cmd_write = 1'b1;
                mem.addr      = next_addr;
                mem.wdata     = merged_high;
            end
            mem_access_pkg::issue_next_before_write,
            mem_access_pkg::issue_next_read: begin
                mem.cmd_start = 1'b1;
                mem.addr      = next_addr;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mem_access_pkg::idle;
        end else begin
            case (state)
                mem_access_pkg::idle: begin
                    if (cmd_start) begin
                        state <= mem_access_pkg::issue_first;
                    end
                end
                mem_access_pkg::issue_first: begin
                    if (mem.cmd_ready) begin
                        if (full_write) begin
                            state <= mem_access_pkg::idle;
                        end else if (save_write) begin
                            state <= mem_access_pkg::read_before_write;
                        end else begin
                            state <= mem_access_pkg::wait_read;
                        end
                    end
                end
                mem_access_pkg::read_before_write: begin
                    if (mem.rdata_valid) begin
                        state <= aligned ? mem_access_pkg::issue_write :
                                           mem_access_pkg::issue_next_before_write;
                    end
                end
                mem_access_pkg::issue_next_before_write: begin
                    if (mem.cmd_ready) begin
                        state <= mem_access_pkg::read_next_before_write;
                    end
                end
                mem_access_pkg::read_next_before_write: begin
                    if (mem.rdata_valid) begin
                        state <= mem_access_pkg::issue_write_low;
                    end
                end
                mem_access_pkg::issue_write_low: begin
                    if (mem.cmd_ready) begin
                        state <= mem_access_pkg::issue_write_high;
                    end
                end
                mem_access_pkg::issue_write,
                mem_access_pkg::issue_write_high: begin
                    // Last write of the request
                    if (mem.cmd_ready) begin
                        state <= mem_access_pkg::idle;
                    end
                end
                mem_access_pkg::wait_read: begin
                    if (mem.rdata_valid) begin
                        state <= aligned ? mem_access_pkg::finish :
                                           mem_access_pkg::issue_next_read;
                    end
                end
                mem_access_pkg::issue_next_read: begin
                    if (mem.cmd_ready) begin
                        state <= mem_access_pkg::wait_next_read;
                    end
                end
                mem_access_pkg::wait_next_read: begin
                    if (mem.rdata_valid) begin
                        state <= mem_access_pkg::finish;
                    end
                end
                default: begin
                    state <= mem_access_pkg::idle;
                end
            endcase
        end
    end

    // Request fields and returned words
    always_ff @(posedge clk) begin
        if (state == mem_access_pkg::idle && cmd_start) begin
            save_write <= cmd_write;
            save_addr  <= addr;
            save_wdata <= wdata;
            save_wmask <= wmask;
        end
        if (mem.rdata_valid) begin
            if (state == mem_access_pkg::read_before_write ||
                state == mem_access_pkg::wait_read) begin
                low_word <= mem.rdata;
            end
            if (state == mem_access_pkg::read_next_before_write) begin
                high_word <= mem.rdata;
            end
        end
    end

endmodule

// File: rtl/memory/word_ram.sv
`timescale 1ns/1ns
`include "mem_access_params.svh"

module word_ram #(
    parameter int WORDS = `MA_MEM_WORDS
) (
    input  logic    clk,
    input  logic    rst,
    mem_word_if.ram mem
);

    localparam int IDX_W = $clog2(WORDS);

    // Storage, cleared at time 0
    mem_access_pkg::word_t mem_array [WORDS] = '{default: '0};

    logic [IDX_W-1:0]      idx;
    logic                  accept;
    logic                  rd_pend;
    mem_access_pkg::word_t rd_data;

    // Word index, upper address bits drop out so it wraps at WORDS
    assign idx    = mem.addr[`MA_OFF_W +: IDX_W];
    assign accept = mem.cmd_start && mem.cmd_ready;

    // Busy for the one cycle a read result is on the bus
    assign mem.cmd_ready   = !rd_pend;
    assign mem.rdata_valid = rd_pend;
    assign mem.rdata       = rd_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= accept && !mem.cmd_write;
        end
    end

    // Writes land at the accepting edge
    always_ff @(posedge clk) begin
        if (accept) begin
            if (mem.cmd_write) begin
                mem_array[idx] <= mem.wdata;
            end else begin
                rd_data <= mem_array[idx];
            end
        end
    end

endmodule

// File: rtl/mem_access_ctrl.sv
`timescale 1ns/1ns

module mem_access_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmd_start,
    input  logic                  cmd_write,
    output logic                  cmd_ready,
    input  mem_access_pkg::addr_t addr,
    input  mem_access_pkg::word_t wdata,
    input  mem_access_pkg::mask_t wmask,
    output mem_access_pkg::word_t rdata,
    output logic                  rdata_valid
);

    // Word bus between sequencer and RAM
    mem_word_if mem_bus ();

    // Saved request fields and old words going to the merger
    mem_access_pkg::byte_off_t offset;
    mem_access_pkg::word_t     save_wdata;
    mem_access_pkg::mask_t     save_wmask;
    mem_access_pkg::word_t     low_word;
    mem_access_pkg::word_t     high_word;

    // Merger results coming back
    mem_access_pkg::word_t     merged_low;
    mem_access_pkg::word_t     merged_high;
    mem_access_pkg::word_t     read_word;

    access_seq seq0 (
        .clk         (clk),
        .rst         (rst),
        .cmd_start   (cmd_start),
        .cmd_write   (cmd_write),
        .cmd_ready   (cmd_ready),
        .addr        (addr),
        .wdata       (wdata),
        .wmask       (wmask),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .mem         (mem_bus),
        .offset      (offset),
        .save_wdata  (save_wdata),
        .save_wmask  (save_wmask),
        .low_word    (low_word),
        .high_word   (high_word),
        .merged_low  (merged_low),
        .merged_high (merged_high),
        .read_word   (read_word)
    );

    lane_merge merge0 (
        .offset      (offset),
        .save_wdata  (save_wdata),
        .save_wmask  (save_wmask),
        .low_word    (low_word),
        .high_word   (high_word),
        .mem_rdata   (mem_bus.rdata),
        .merged_low  (merged_low),
        .merged_high (merged_high),
        .read_word   (read_word)
    );

    word_ram ram0 (
        .clk (clk),
        .rst (rst),
        .mem (mem_bus)
    );

endmodule

// File: test/tb_mem_access.sv
`timescale 1ns/1ns
`include "mem_access_params.svh"

module tb_mem_access;

    localparam int CLK_PERIOD = 4;
    localparam int RAM_WORDS  = `MA_MEM_WORDS;
    localparam int RAM_BYTES  = 4 * RAM_WORDS;

    // Operations per test for the watchdog budget
    localparam int FULL_OPS   = 32;
    localparam int MASK_OPS   = 32;
    localparam int OFF_RD_OPS = 19;
    localparam int OFF_WR_OPS = 65;
    localparam int MIX_OPS    = 400;
    localparam int TOTAL_OPS  = FULL_OPS + MASK_OPS + OFF_RD_OPS + OFF_WR_OPS + MIX_OPS;
    // Sixteen cycles per operation covers the longest request with room to spare
    localparam int TIMEOUT_NS = TOTAL_OPS * 16 * CLK_PERIOD + 20 * CLK_PERIOD;

    logic                  clk;
    logic                  rst;
    logic                  cmd_start;
    logic                  cmd_write;
    logic                  cmd_ready;
    mem_access_pkg::addr_t addr;
    mem_access_pkg::word_t wdata;
    mem_access_pkg::mask_t wmask;
    mem_access_pkg::word_t rdata;
    logic                  rdata_valid;

    int seed;
    int checks;
    int errors;
    int mark_checks;
    int mark_errors;

    // Reference memory with one entry per byte address
    logic [7:0] model_mem [RAM_BYTES];
    mem_access_pkg::word_t full_data [16];

    mem_access_ctrl dut0 (
        .clk         (clk),
        .rst         (rst),
        .cmd_start   (cmd_start),
        .cmd_write   (cmd_write),
        .cmd_ready   (cmd_ready),
        .addr        (addr),
        .wdata       (wdata),
        .wmask       (wmask),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Byte address folded into the RAM size
    function automatic int byte_index(input mem_access_pkg::addr_t a, input int i);
        logic [31:0] sum;
        sum = a + 32'(i);
        return int'(sum % 32'(RAM_BYTES));
    endfunction

    function automatic mem_access_pkg::addr_t word_addr(input int w);
        return mem_access_pkg::addr_t'(w * 4);
    endfunction

    // Little-endian with byte i taken from addr+i
    function automatic mem_access_pkg::word_t ref_word(input mem_access_pkg::addr_t a);
        mem_access_pkg::word_t w;
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = model_mem[byte_index(a, i)];
        end
        return w;
    endfunction

    // Mask bit set takes the new bit
    function automatic void apply_write(input mem_access_pkg::addr_t a,
                                        input mem_access_pkg::word_t d,
                                        input mem_access_pkg::mask_t m);
        int k;
        for (int i = 0; i < 4; i++) begin
            k = byte_index(a, i);
            model_mem[k] = (model_mem[k] & ~m[8*i +: 8]) | (d[8*i +: 8] & m[8*i +: 8]);
        end
    endfunction

    function automatic mem_access_pkg::word_t rand_word();
        mem_access_pkg::word_t r;
        r = $random(seed);
        return r;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(n));
    endfunction

    // Bit 0 picks the low 16 words or the top 16 bytes
    function automatic mem_access_pkg::addr_t rand_addr();
        logic [31:0] r;
        r = $random(seed);
        if (r[0]) begin
            return mem_access_pkg::addr_t'(RAM_BYTES - 16) + mem_access_pkg::addr_t'(r[4:1]);
        end
        return mem_access_pkg::addr_t'(r[6:1]);
    endfunction

    task automatic check_word(input mem_access_pkg::word_t got,
                              input mem_access_pkg::word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    // Request goes out on a falling edge once the DUT is idle
    task automatic drive_write(input mem_access_pkg::addr_t a,
                               input mem_access_pkg::word_t d,
                               input mem_access_pkg::mask_t m);
        @(negedge clk);
        while (!cmd_ready) @(negedge clk);
        cmd_start = 1'b1;
        cmd_write = 1'b1;
        addr      = a;
        wdata     = d;
        wmask     = m;
        @(negedge clk);
        cmd_start = 1'b0;
        check_bit(cmd_ready, 1'b0, "cmd_ready low after write accept");
        // No read strobe may show up for a write
        while (!cmd_ready) begin
            check_bit(rdata_valid, 1'b0, "rdata_valid during write");
            @(negedge clk);
        end
        apply_write(a, d, m);
    endtask

    task automatic drive_read(input mem_access_pkg::addr_t a,
                              output mem_access_pkg::word_t got);
        @(negedge clk);
        while (!cmd_ready) @(negedge clk);
        cmd_start = 1'b1;
        cmd_write = 1'b0;
        addr      = a;
        @(negedge clk);
        cmd_start = 1'b0;
        while (!rdata_valid) @(negedge clk);
        got = rdata;
        // Strobe is a single cycle
        @(negedge clk);
        check_bit(rdata_valid, 1'b0, "rdata_valid dropped after one cycle");
    endtask

    task automatic read_and_compare(input mem_access_pkg::addr_t a, input string what);
        mem_access_pkg::word_t got;
        drive_read(a, got);
        check_word(got, ref_word(a), $sformatf("%s at %h", what, a));
    endtask

    task automatic begin_test();
        mark_checks = checks;
        mark_errors = errors;
    endtask

    task automatic end_test(input string name);
        $display("[%0t ns] %s: %0d checks, %0d errors", $time, name,
                 checks - mark_checks, errors - mark_errors);
    endtask

    task automatic reset_state_check();
        begin_test();
        check_bit(cmd_ready, 1'b1, "cmd_ready after reset");
        check_bit(rdata_valid, 1'b0, "rdata_valid after reset");
        end_test("reset state");
    endtask

    task automatic full_word_writes();
        mem_access_pkg::word_t got;
        begin_test();
        for (int w = 0; w < 16; w++) begin
            full_data[w] = rand_word();
            drive_write(word_addr(w), full_data[w], `MA_FULL_MASK);
        end
        for (int w = 0; w < 16; w++) begin
            drive_read(word_addr(w), got);
            check_word(got, full_data[w], $sformatf("full write readback word %0d", w));
        end
        end_test("full-mask aligned writes");
    endtask

    task automatic masked_word_writes();
        mem_access_pkg::word_t old;
        mem_access_pkg::word_t d;
        mem_access_pkg::mask_t m;
        mem_access_pkg::word_t got;
        begin_test();
        for (int w = 0; w < 16; w++) begin
            old = ref_word(word_addr(w));
            d   = rand_word();
            m   = rand_word();
            drive_write(word_addr(w), d, m);
            drive_read(word_addr(w), got);
            check_word(got, (old & ~m) | (d & m), $sformatf("masked write word %0d", w));
        end
        end_test("masked aligned writes");
    endtask

    task automatic offset_reads();
        begin_test();
        // Give the top words content so the wrap is visible
        for (int w = RAM_WORDS - 4; w < RAM_WORDS; w++) begin
            drive_write(word_addr(w), rand_word(), `MA_FULL_MASK);
        end
        for (int w = 0; w < 4; w++) begin
            for (int off = 1; off < 4; off++) begin
                read_and_compare(word_addr(w) + mem_access_pkg::addr_t'(off), "offset read");
            end
        end
        // Last word spills into word 0
        for (int off = 1; off < 4; off++) begin
            read_and_compare(word_addr(RAM_WORDS - 1) + mem_access_pkg::addr_t'(off),
                             "wrapping read");
        end
        end_test("unaligned reads");
    endtask

    task automatic offset_writes();
        int w;
        int off;
        begin_test();
        for (int k = 0; k < 12; k++) begin
            w   = 1 + rand_below(13);
            off = 1 + rand_below(3);
            drive_write(word_addr(w) + mem_access_pkg::addr_t'(off), rand_word(), rand_word());
            // Both target words and one neighbor on each side
            for (int n = w - 1; n <= w + 2; n++) begin
                read_and_compare(word_addr(n), "after unaligned write");
            end
        end
        // Write at the top byte wraps its high word to word 0
        drive_write(mem_access_pkg::addr_t'(RAM_BYTES - 1), rand_word(), rand_word());
        read_and_compare(word_addr(RAM_WORDS - 2), "after wrapping write");
        read_and_compare(word_addr(RAM_WORDS - 1), "after wrapping write");
        read_and_compare(word_addr(0), "after wrapping write");
        read_and_compare(word_addr(1), "after wrapping write");
        end_test("unaligned masked writes");
    endtask

    task automatic random_mix();
        mem_access_pkg::addr_t a;
        mem_access_pkg::mask_t m;
        begin_test();
        for (int i = 0; i < MIX_OPS; i++) begin
            a = rand_addr();
            if (rand_below(2) == 0) begin
                // A quarter of the writes use the full mask
                m = (rand_below(4) == 0) ? `MA_FULL_MASK : rand_word();
                drive_write(a, rand_word(), m);
            end else begin
                read_and_compare(a, "random read");
            end
        end
        end_test("random mix");
    endtask

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Test failed");
        $finish;
    end

    initial begin
        seed      = 77;
        checks    = 0;
        errors    = 0;
        rst       = 1'b1;
        cmd_start = 1'b0;
        cmd_write = 1'b0;
        addr      = '0;
        wdata     = '0;
        wmask     = '0;
        // Model starts at zero like the RAM
        for (int i = 0; i < RAM_BYTES; i++) begin
            model_mem[i] = 8'h00;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        reset_state_check();
        full_word_writes();
        masked_word_writes();
        offset_reads();
        offset_writes();
        random_mix();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+common
common/mem_access_pkg.sv
common/mem_word_if.sv
rtl/access_ctrl/lane_merge.sv
rtl/access_ctrl/access_seq.sv
rtl/memory/word_ram.sv
rtl/mem_access_ctrl.sv
test/tb_mem_access.sv

// File: Makefile
# Verilator flow for the memory access controller

VERILATOR ?= verilator
TOP       ?= tb_mem_access
RTL_TOP   ?= mem_access_ctrl
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# The log decides the result, not the simulator exit code
sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
